//--- Bender.yml
package:
  name: ddr_port

sources:
  # packages first, then the design from the leaves up
  - src/axi_pkg.sv
  - src/mem_pkg.sv
  - src/mem_fifo.sv
  - src/ddr_master.sv
  - src/axi_mem.sv
  - src/ddr_port_top.sv

  - target: test
    files:
      - bench/ddr_port_assertions.sv
      - bench/ddr_port_tb.sv

//--- bench/ddr_port_assertions.sv
module ddr_port_assertions
    import axi_pkg::*;
    import mem_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input axi_aw_t  aw,
    input logic     awvalid,
    input logic     awready,
    input axi_w_t   w,
    input logic     wvalid,
    input logic     wready,
    input axi_ar_t  ar,
    input logic     arvalid,
    input logic     arready,
    input mem_rsp_t rsp_in,
    input logic     rsp_in_valid,
    input logic     rsp_in_ready
);

    // bench adds this to its error total at the end
    int fail_count = 0;

    // channel payloads held while the memory stalls
    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
    else begin
        fail_count++;
        $error("aw dropped or changed while awready low");
    end

    assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(w))
    else begin
        fail_count++;
        $error("w dropped or changed while wready low");
    end

    assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
    else begin
        fail_count++;
        $error("ar dropped or changed while arready low");
    end

    // one address channel at a time
    assert property (@(posedge clk) disable iff (rst)
        !(arvalid && awvalid))
    else begin
        fail_count++;
        $error("arvalid and awvalid high together");
    end

    assert property (@(posedge clk) disable iff (rst)
        rsp_in_valid && !rsp_in_ready |=> rsp_in_valid && $stable(rsp_in))
    else begin
        fail_count++;
        $error("rsp_in dropped or changed before rsp_in_ready");
    end

endmodule

//--- bench/ddr_port_tb.sv
module ddr_port_tb
    import axi_pkg::*;
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 64
);

    localparam int N_MIX      = 200;
    localparam int TOTAL_REQS = 25 + N_MIX;
    localparam int MAX_CYCLES = TOTAL_REQS * 20 + 100;
    // word indices the 27-bit address can reach
    localparam int ADDR_WORDS = 2 ** (ADDR_W - BYTE_BITS);
    // out of range step whose low index bits wrap back into the array
    localparam int ALIAS_STEP = 2 ** $clog2(MEM_WORDS);

    logic     clk;
    logic     rst;
    mem_req_t req;
    logic     req_valid;
    logic     req_ready;
    mem_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_ready;
    logic     wr_err;

    // reference model
    axi_data_t model_mem [MEM_WORDS];
    mem_rsp_t  exp_q [$];
    logic      exp_wr_err;

    logic [31:0] rnd_state;
    logic [31:0] bp_state;
    logic        bp_en;

    int cycles;
    int errors;
    int checks;
    int test_num;
    int test_start;
    int reads_sent;
    int rsps_seen;
    int words [4];

    ddr_port_top #(
        .MEM_WORDS (MEM_WORDS),
        .REQ_DEPTH (4),
        .RSP_DEPTH (2)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .wr_err    (wr_err)
    );

    bind ddr_master ddr_port_assertions u_checks (
        .clk          (clk),
        .rst          (rst),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .rsp_in       (rsp_in),
        .rsp_in_valid (rsp_in_valid),
        .rsp_in_ready (rsp_in_ready)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = lcg_step(rnd_state);
        // fold the weak low bits with the high ones
        return rnd_state ^ (rnd_state >> 16);
    endfunction

    function automatic axi_data_t rand_data();
        return {next_rand(), next_rand(), next_rand(), next_rand()};
    endfunction

    function automatic axi_strb_t rand_strb();
        logic [31:0] v;
        v = next_rand();
        return v[STRB_W-1:0];
    endfunction

    function automatic int in_word();
        return int'(next_rand() % MEM_WORDS);
    endfunction

    function automatic int out_word();
        return MEM_WORDS + int'(next_rand() % (ADDR_WORDS - MEM_WORDS));
    endfunction

    // random byte offset inside the word
    function automatic mem_req_t make_req(input logic wr, input int word,
                                          input axi_data_t data, input axi_strb_t strb);
        mem_req_t    r;
        logic [31:0] low;
        low    = next_rand();
        r.wr   = wr;
        r.addr = axi_addr_t'(word * STRB_W + int'(low % STRB_W));
        r.data = data;
        r.strb = strb;
        return r;
    endfunction

    task automatic model_request(input mem_req_t r);
        int idx;
        idx = int'(r.addr / STRB_W);
        if (r.wr) begin
            if (idx < MEM_WORDS) begin
                for (int i = 0; i < STRB_W; i++) begin
                    if (r.strb[i]) begin
                        model_mem[idx][8*i +: 8] = r.data[8*i +: 8];
                    end
                end
            end else begin
                exp_wr_err = 1'b1;
            end
        end else begin
            reads_sent++;
            if (idx < MEM_WORDS) begin
                exp_q.push_back('{data: model_mem[idx], err: 1'b0});
            end else begin
                exp_q.push_back('{data: '0, err: 1'b1});
            end
        end
    endtask

    task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got data %h err %b, expected data %h err %b",
                     $time, what, got.data, got.err, exp.data, exp.err);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // called just after a rising edge
    task automatic send_req(input mem_req_t r);
        req       <= r;
        req_valid <= 1'b1;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic do_write(input int word, input axi_data_t data, input axi_strb_t strb);
        send_req(make_req(1'b1, word, data, strb));
    endtask

    task automatic do_read(input int word);
        send_req(make_req(1'b0, word, '0, '0));
    endtask

    // in-order service, so an empty queue means all earlier requests are done
    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == test_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - test_start);
        end
        test_start = errors;
    endtask

    // model update on every request handshake, compare on every response
    always @(posedge clk) begin
        if (!rst) begin
            if (req_valid && req_ready) begin
                model_request(req);
            end
            if (rsp_valid && rsp_ready) begin
                rsps_seen++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("a response arrived at %0t with no read outstanding", $time);
                end else begin
                    check_rsp(rsp, exp_q.pop_front(), "read return");
                end
            end
        end
    end

    always @(posedge clk) begin
        bp_state <= lcg_step(bp_state);
        if (bp_en) begin
            rsp_ready <= bp_state[20];
        end else begin
            rsp_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("the run timed out after %0d cycles", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int       fails;
        int       word;
        mem_req_t mix;
        logic [31:0] r;

        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        req_valid  = 1'b0;
        rsp_ready  = 1'b1;
        bp_en      = 1'b0;
        rnd_state  = 32'd22337;
        bp_state   = 32'd22337 ^ 32'h9e3779b9;
        exp_wr_err = 1'b0;
        cycles     = 0;
        errors     = 0;
        checks     = 0;
        test_num   = 0;
        test_start = 0;
        reads_sent = 0;
        rsps_seen  = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_flag(req_ready, 1'b1, "req_ready after reset");
        check_flag(rsp_valid, 1'b0, "rsp_valid after reset");
        check_flag(wr_err, 1'b0, "wr_err after reset");
        do_read(0);
        do_read(in_word());
        drain();
        end_test("reset state");

        for (int k = 0; k < 4; k++) begin
            words[k] = in_word();
            do_write(words[k], rand_data(), '1);
        end
        for (int k = 0; k < 4; k++) begin
            do_read(words[k]);
        end
        drain();
        end_test("full write and readback");

        for (int k = 0; k < 4; k++) begin
            do_write(words[k], rand_data(), rand_strb());
        end
        for (int k = 0; k < 4; k++) begin
            do_read(words[k]);
        end
        drain();
        end_test("partial strobe merge");

        do_read(MEM_WORDS);
        do_read(out_word());
        drain();
        end_test("read out of range");

        check_flag(wr_err, 1'b0, "wr_err before bad write");
        // a truncated index would land on words[0]
        do_write(words[0] + ALIAS_STEP, rand_data(), '1);
        do_read(words[0]);
        drain();
        check_flag(wr_err, exp_wr_err, "wr_err after bad write");
        do_write(words[1], rand_data(), '1);
        do_read(words[1]);
        drain();
        check_flag(wr_err, exp_wr_err, "wr_err after later write");
        end_test("write out of range");

        bp_en <= 1'b1;
        for (int n = 0; n < N_MIX; n++) begin
            r = next_rand();
            // roughly one in sixteen leaves the memory
            word = (r[11:8] == 4'd0) ? out_word() : in_word();
            if (r[4]) begin
                mix = make_req(1'b1, word, rand_data(), rand_strb());
            end else begin
                mix = make_req(1'b0, word, '0, '0);
            end
            send_req(mix);
        end
        bp_en <= 1'b0;
        do_read(in_word());
        drain();
        checks++;
        if (reads_sent != rsps_seen) begin
            errors++;
            $display("responses lost: %0d reads sent but %0d responses seen",
                     reads_sent, rsps_seen);
        end
        check_flag(wr_err, exp_wr_err, "wr_err after random mix");
        end_test("random mix with back-pressure");

        fails = errors + uut.u_master.u_checks.fail_count;
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_num, checks, errors, uut.u_master.u_checks.fail_count);
        if (fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- ddr_port.f
src/axi_pkg.sv
src/mem_pkg.sv
src/mem_fifo.sv
src/ddr_master.sv
src/axi_mem.sv
src/ddr_port_top.sv
bench/ddr_port_assertions.sv
bench/ddr_port_tb.sv

//--- src/axi_mem.sv
module axi_mem
    import axi_pkg::*;
#(
    parameter int MEM_WORDS = 64
) (
    input  logic    clk,
    input  logic    rst,

    input  axi_aw_t aw,
    input  logic    awvalid,
    output logic    awready,

    input  axi_w_t  w,
    input  logic    wvalid,
    output logic    wready,

    output axi_b_t  b,
    output logic    bvalid,
    input  logic    bready,

    input  axi_ar_t ar,
    input  logic    arvalid,
    output logic    arready,

    output axi_r_t  r,
    output logic    rvalid,
    input  logic    rready
);

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {
        M_IDLE,
        M_WDATA,
        M_BRESP,
        M_RDATA
    } state_t;

    state_t    state;
    axi_data_t mem [MEM_WORDS];
    axi_addr_t waddr;
    axi_resp_t bresp_q;
    axi_data_t rdata_q;
    axi_resp_t rresp_q;

    // word index check against the array size
    function automatic logic in_range(input axi_addr_t addr);
        return (addr[ADDR_W-1:BYTE_BITS] < MEM_WORDS);
    endfunction

    function automatic logic [IDX_W-1:0] word_idx(input axi_addr_t addr);
        return addr[BYTE_BITS +: IDX_W];
    endfunction

    // a write wins when both address channels show up together
    assign awready = (state == M_IDLE);
    assign arready = (state == M_IDLE) && !awvalid;
    assign wready  = (state == M_WDATA);
    assign bvalid  = (state == M_BRESP);
    assign rvalid  = (state == M_RDATA);

    assign b.resp = bresp_q;
    assign r.data = rdata_q;
    assign r.resp = rresp_q;
    assign r.last = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= M_IDLE;
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                M_IDLE: begin
                    if (awvalid) begin
                        state <= M_WDATA;
                        waddr <= aw.addr;
                    end else if (arvalid) begin
                        state <= M_RDATA;
                        // out of range reads as zero
                        if (in_range(ar.addr)) begin
                            rdata_q <= mem[word_idx(ar.addr)];
                            rresp_q <= resp_okay;
                        end else begin
                            rdata_q <= '0;
                            rresp_q <= resp_slverr;
                        end
                    end
                end
                M_WDATA: begin
                    if (wvalid) begin
                        state <= M_BRESP;
                        // single beat only, a missing last is refused
                        if (in_range(waddr) && w.last) begin
                            bresp_q <= resp_okay;
                            for (int i = 0; i < STRB_W; i++) begin
                                if (w.strb[i]) begin
                                    mem[word_idx(waddr)][8*i +: 8] <= w.data[8*i +: 8];
                                end
                            end
                        end else begin
                            bresp_q <= resp_slverr;
                        end
                    end
                end
                M_BRESP: begin
                    if (bready) begin
                        state <= M_IDLE;
                    end
                end
                M_RDATA: begin
                    if (rready) begin
                        state <= M_IDLE;
                    end
                end
                default: begin
                    state <= M_IDLE;
                end
            endcase
        end
    end

endmodule

//--- src/axi_pkg.sv
package axi_pkg;

    // bus geometry
    localparam int ADDR_W = 27;
    localparam int DATA_W = 128;
    localparam int STRB_W = DATA_W / 8;

    // low address bits that select a byte within one data word
    localparam int BYTE_BITS = $clog2(STRB_W);

    typedef logic [ADDR_W-1:0] axi_addr_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]        axi_resp_t;

    localparam axi_resp_t resp_okay   = 2'b00;
    localparam axi_resp_t resp_slverr = 2'b10;

    // write address
    typedef struct packed {
        axi_addr_t addr;
    } axi_aw_t;

    // write data, always a single beat
    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
        logic      last;
    } axi_w_t;

    typedef struct packed {
        axi_resp_t resp;
    } axi_b_t;

    // read address
    typedef struct packed {
        axi_addr_t addr;
    } axi_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

endpackage

//--- src/ddr_master.sv
module ddr_master
    import axi_pkg::*;
    import mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // request from the cache side queue
    input  mem_req_t cmd,
    input  logic     cmd_valid,
    output logic     cmd_ready,

    // write address
    output axi_aw_t  aw,
    output logic     awvalid,
    input  logic     awready,

    // write data
    output axi_w_t   w,
    output logic     wvalid,
    input  logic     wready,

    // write response
    input  axi_b_t   b,
    input  logic     bvalid,
    output logic     bready,

    // read address
    output axi_ar_t  ar,
    output logic     arvalid,
    input  logic     arready,

    // read data
    input  axi_r_t   r,
    input  logic     rvalid,
    output logic     rready,

    // read return toward the response queue
    output mem_rsp_t rsp_in,
    output logic     rsp_in_valid,
    input  logic     rsp_in_ready,

    output logic     wr_err
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_RESP,
        S_RET
    } state_t;

    state_t   state;
    mem_req_t cur;
    mem_rsp_t rsp_q;

    logic addr_done;

    // handshakes are decoded from the phase and the held command
    assign cmd_ready = (state == S_IDLE);

    assign awvalid = (state == S_ADDR) && cur.wr;
    assign arvalid = (state == S_ADDR) && !cur.wr;
    assign wvalid  = (state == S_DATA);
    assign bready  = (state == S_RESP) && cur.wr;
    assign rready  = (state == S_RESP) && !cur.wr;

    assign rsp_in_valid = (state == S_RET);
    assign rsp_in       = rsp_q;

    // payloads come straight from the held command
    assign aw.addr = cur.addr;
    assign ar.addr = cur.addr;
    assign w.data  = cur.data;
    assign w.strb  = cur.strb;
    assign w.last  = 1'b1;

    assign addr_done = cur.wr ? awready : arready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_IDLE;
            wr_err <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_valid) begin
                        state <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    // reads skip the data phase
                    if (addr_done) begin
                        state <= cur.wr ? S_DATA : S_RESP;
                    end
                end
                S_DATA: begin
                    if (wready) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (cur.wr) begin
                        if (bvalid) begin
                            state <= S_IDLE;
                            // sticky until reset
                            if (b.resp == resp_slverr) begin
                                wr_err <= 1'b1;
                            end
                        end
                    end else if (rvalid) begin
                        state <= S_RET;
                    end
                end
                S_RET: begin
                    if (rsp_in_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // held command and captured read return
    always_ff @(posedge clk) begin
        if (cmd_valid && cmd_ready) begin
            cur <= cmd;
        end
        if (rvalid && rready) begin
            rsp_q.data <= r.data;
            rsp_q.err  <= (r.resp != resp_okay);
        end
    end

endmodule

//--- src/ddr_port_top.sv
module ddr_port_top
    import axi_pkg::*;
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 64,
    parameter int REQ_DEPTH = 4,
    parameter int RSP_DEPTH = 2
) (
    input  logic     clk,
    input  logic     rst,

    input  mem_req_t req,
    input  logic     req_valid,
    output logic     req_ready,

    output mem_rsp_t rsp,
    output logic     rsp_valid,
    input  logic     rsp_ready,

    output logic     wr_err
);

    // queue to master
    mem_req_t cmd;
    logic     cmd_valid;
    logic     cmd_ready;

    // master to response queue
    mem_rsp_t rsp_in;
    logic     rsp_in_valid;
    logic     rsp_in_ready;

    // axi channels between master and memory
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    axi_b_t  b;
    logic    bvalid;
    logic    bready;
    axi_ar_t ar;
    logic    arvalid;
    logic    arready;
    axi_r_t  r;
    logic    rvalid;
    logic    rready;

    mem_fifo #(
        .item_t (mem_req_t),
        .DEPTH  (REQ_DEPTH)
    ) u_req_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (req),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .out_data  (cmd),
        .out_valid (cmd_valid),
        .out_ready (cmd_ready)
    );

    ddr_master u_master (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .b            (b),
        .bvalid       (bvalid),
        .bready       (bready),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .r            (r),
        .rvalid       (rvalid),
        .rready       (rready),
        .rsp_in       (rsp_in),
        .rsp_in_valid (rsp_in_valid),
        .rsp_in_ready (rsp_in_ready),
        .wr_err       (wr_err)
    );

    // stands in for the ddr controller
    axi_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready),
        .b       (b),
        .bvalid  (bvalid),
        .bready  (bready),
        .ar      (ar),
        .arvalid (arvalid),
        .arready (arready),
        .r       (r),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    mem_fifo #(
        .item_t (mem_rsp_t),
        .DEPTH  (RSP_DEPTH)
    ) u_rsp_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_data   (rsp_in),
        .in_valid  (rsp_in_valid),
        .in_ready  (rsp_in_ready),
        .out_data  (rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready)
    );

endmodule

//--- src/mem_fifo.sv
module mem_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  rst,

    input  item_t in_data,
    input  logic  in_valid,
    output logic  in_ready,

    output item_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            buf_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    // ready follows the fill level only
    assign in_ready  = (count < CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = buf_q[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the level
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- src/mem_pkg.sv
package mem_pkg;

    import axi_pkg::*;

    // one cache line request
    // wr low means a read, and data and strb are then ignored
    typedef struct packed {
        logic      wr;
        axi_addr_t addr;
        axi_data_t data;
        axi_strb_t strb;
    } mem_req_t;

    // read return to the cache
    // err is set when the slave did not answer okay
    typedef struct packed {
        axi_data_t data;
        logic      err;
    } mem_rsp_t;

endpackage
